/* usbAudio_params.svh */
//--------------------------------------------------------------------------
// USB audio constants
//--------------------------------------------------------------------------
`ifndef USBAUDIO_PARAMS_SVH
`define USBAUDIO_PARAMS_SVH

// Standard requests
`define SET_ADDRESS       8'd5
`define SET_CONFIGURATION 8'd9
`define SET_INTERFACE     8'd11

// Audio class requests
`define SET_CUR           8'h01
`define GET_CUR           8'h81
`define GET_MIN           8'h82
`define GET_MAX           8'h83
`define GET_RES           8'h84

// Feature unit control selectors
`define MUTE_CONTROL      8'd1
`define VOLUME_CONTROL    8'd2

`define FEATURE_UNIT      8'd2   // Unit ID of the speaker feature unit
`define STREAM_INTERFACE  8'd1   // Alternate setting here turns playback on

// Volume range, 1/256 dB steps
`define VOLUME_DEFAULT    16'd868  // Low but audible host slider position
`define VOLUME_MIN        16'h0000
`define VOLUME_MAX        16'h7FFF
`define VOLUME_RES        16'h0001

// Sample buffer
`define FIFO_ADDR_BITS    8       // 256 stereo words
`define FIFO_START_LEVEL  8'h80   // Start playback above this fill
`define FIFO_STOP_LEVEL   8'h20   // Stop playback below this fill

`endif

/* usbAudioPkg.sv */
//--------------------------------------------------------------------------
// USB audio shared types
//--------------------------------------------------------------------------
package usbAudioPkg;

   //-----------------------------------------------------------------------
   // Transceiver packet streams
   //-----------------------------------------------------------------------

   // OUT byte stream, host to device
   typedef struct packed {
      logic       valid;      // Byte or strobe present this cycle
      logic       sop;        // First byte of a packet
      logic       eop;        // End of packet, carries no data
      logic       setup;      // Packet came in a SETUP token
      logic [7:0] data;
   } rxPktT;

   // IN byte stream, device to host
   typedef struct packed {
      logic       ready;      // Byte or zero-length packet on offer
      logic       seq;        // DATA0/DATA1 toggle
      logic       zeroLength; // Send an empty packet
      logic [7:0] data;
   } txPktT;

   //-----------------------------------------------------------------------
   // Control transfer
   //-----------------------------------------------------------------------
   typedef struct packed {
      logic        direction;  // 1 = device to host
      logic [1:0]  reqType;    // 0 standard, 1 class
      logic [4:0]  recipient;
      logic [7:0]  request;
      logic [15:0] value;      // Selector high, channel low for class requests
      logic [15:0] index;      // Unit high, interface low
   } setupT;

   //-----------------------------------------------------------------------
   // Audio
   //-----------------------------------------------------------------------

   // Left in the low half, same as byte order on the bus
   typedef struct packed {
      logic signed [15:0] right;
      logic signed [15:0] left;
   } sampleT;

   typedef struct packed {
      logic [15:0] right;
      logic [15:0] left;
   } volumeT;

endpackage

/* setupParser.sv */
//--------------------------------------------------------------------------
// Endpoint 0 setup packet parser
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module setupParser (
   input  logic                Clk,
   input  logic                rst,
   input  logic [3:0]          endpoint,
   input  usbAudioPkg::rxPktT  rx,
   output usbAudioPkg::rxPktT  ep0Rx,
   output usbAudioPkg::setupT  setup,
   output logic                setupDone
);

   logic [3:0] byteCount;   // 0 idle, 1..7 collecting, 8 waiting for EoP
   logic       startSetup;

   // Only endpoint 0 traffic is passed on
   always_comb begin
      ep0Rx       = rx;
      ep0Rx.valid = rx.valid && (endpoint == 4'd0);
   end

   assign startSetup = ep0Rx.valid && ep0Rx.sop && ep0Rx.setup;
   assign setupDone  = ep0Rx.valid && ep0Rx.eop && (byteCount == 4'd8);

   //-----------------------------------------------------------------------
   // Byte counter
   //-----------------------------------------------------------------------
   always_ff @(posedge Clk) begin
      if (rst) begin
         byteCount <= 4'd0;
      end else if (startSetup) begin
         byteCount <= 4'd1;                 // New SETUP always restarts
      end else if (ep0Rx.valid && byteCount != 4'd0) begin
         if (ep0Rx.eop)
            byteCount <= 4'd0;              // Done, or short packet dropped
         else if (byteCount != 4'd8)
            byteCount <= byteCount + 4'd1;
      end
   end

   // Setup fields, little endian
   always_ff @(posedge Clk) begin
      if (startSetup) begin
         {setup.direction, setup.reqType, setup.recipient} <= ep0Rx.data;
      end else if (ep0Rx.valid && !ep0Rx.eop) begin
         case (byteCount)
            4'd1:    setup.request      <= ep0Rx.data;
            4'd2:    setup.value[7:0]   <= ep0Rx.data;
            4'd3:    setup.value[15:8]  <= ep0Rx.data;
            4'd4:    setup.index[7:0]   <= ep0Rx.data;
            4'd5:    setup.index[15:8]  <= ep0Rx.data;
            default: ;                      // Length bytes not needed
         endcase
      end
   end

endmodule

/* controlEndpoint.sv */
//--------------------------------------------------------------------------
// Endpoint 0 control request handler
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "usbAudio_params.svh"

module controlEndpoint (
   input  logic                 Clk,
   input  logic                 rst,
   input  logic                 busReset,
   input  usbAudioPkg::rxPktT   ep0Rx,
   input  usbAudioPkg::setupT   setup,
   input  logic                 setupDone,
   input  logic                 inWaitRequest,
   input  logic                 inAck,
   input  logic                 error,
   output usbAudioPkg::txPktT   tx,
   output logic                 stall,
   output logic [6:0]           address,
   output logic                 active,
   output logic                 mute,
   output usbAudioPkg::volumeT  volume
);

   typedef enum logic [2:0] {
      IDLE, DECODE, SET_DATA, STATUS, SEND, WAIT_ACK, GET_STATUS
   } stateT;

   stateT       state;
   logic        busResetQ;
   logic        ctlRst;
   logic [7:0]  shiftReg;        // Reply bytes still to go
   logic [1:0]  bytesLeft;
   logic [15:0] setValue;        // SET_CUR payload
   logic        gotLow;
   logic [15:0] reply;
   logic [1:0]  replyLen;
   logic        getOk, stdOk;
   logic        isStd, isClass, toUnit;
   logic        selMute, selVolL, selVolR, selVol;

   //-----------------------------------------------------------------------
   // Request decode
   //-----------------------------------------------------------------------
   assign isStd   = setup.reqType == 2'b00;
   assign isClass = setup.reqType == 2'b01;
   assign toUnit  = setup.index == {`FEATURE_UNIT, 8'd0};   // Unit high, iface 0
   assign selMute = toUnit && setup.value == {`MUTE_CONTROL, 8'd0};
   assign selVolL = toUnit && setup.value == {`VOLUME_CONTROL, 8'd1};
   assign selVolR = toUnit && setup.value == {`VOLUME_CONTROL, 8'd2};
   assign selVol  = selVolL || selVolR;

   assign stdOk = isStd && (setup.request == `SET_ADDRESS ||
                            setup.request == `SET_CONFIGURATION ||
                            setup.request == `SET_INTERFACE);

   // Reply value for GET requests, also used to resend after an error
   always_comb begin
      reply    = 16'h0000;
      replyLen = 2'd2;
      getOk    = 1'b0;
      if (isClass) begin
         case (setup.request)
            `GET_CUR: begin
               getOk = selMute || selVol;
               if (selMute) begin
                  reply    = {15'd0, mute};
                  replyLen = 2'd1;          // Mute is a single byte
               end else if (selVolL) begin
                  reply = volume.left;
               end else begin
                  reply = volume.right;
               end
            end
            `GET_MIN: begin getOk = selVol; reply = `VOLUME_MIN; end
            `GET_MAX: begin getOk = selVol; reply = `VOLUME_MAX; end
            `GET_RES: begin getOk = selVol; reply = `VOLUME_RES; end
            default: ;
         endcase
      end
   end

   //-----------------------------------------------------------------------
   // Bus reset, one register stage
   //-----------------------------------------------------------------------
   always_ff @(posedge Clk) begin
      if (rst) busResetQ <= 1'b0;
      else     busResetQ <= busReset;
   end

   assign ctlRst = rst || busResetQ;

   //-----------------------------------------------------------------------
   // Control transfer FSM
   //-----------------------------------------------------------------------
   always_ff @(posedge Clk) begin
      if (ctlRst) begin
         state         <= IDLE;
         stall         <= 1'b0;
         address       <= 7'd0;
         active        <= 1'b0;                 // No streaming
         mute          <= 1'b0;
         volume        <= '{right: `VOLUME_DEFAULT, left: `VOLUME_DEFAULT};
         tx.ready      <= 1'b0;
         tx.seq        <= 1'b0;
         tx.zeroLength <= 1'b0;
      end else if (setupDone) begin
         state    <= DECODE;                    // SETUP overrides anything pending
         stall    <= 1'b0;
         tx.ready <= 1'b0;
         tx.seq   <= 1'b1;                      // Data stage starts at DATA1
      end else begin
         case (state)
            IDLE: ;
            DECODE: begin
               gotLow <= 1'b0;
               if (stdOk) begin
                  tx.ready      <= 1'b1;        // Status only
                  tx.zeroLength <= 1'b1;
                  state         <= STATUS;
               end else if (isClass && setup.request == `SET_CUR && (selMute || selVol)) begin
                  state <= SET_DATA;
               end else if (getOk) begin
                  {shiftReg, tx.data} <= reply;
                  bytesLeft           <= replyLen;
                  tx.ready            <= 1'b1;
                  tx.zeroLength       <= 1'b0;
                  state               <= SEND;
               end else begin
                  stall <= 1'b1;                // Unsupported
                  state <= IDLE;
               end
            end
            SET_DATA: begin
               if (ep0Rx.valid && ep0Rx.eop) begin
                  if (selMute)      mute         <= setValue[0];
                  else if (selVolL) volume.left  <= setValue;
                  else              volume.right <= setValue;
                  tx.ready      <= 1'b1;
                  tx.zeroLength <= 1'b1;
                  state         <= STATUS;
               end else if (ep0Rx.valid) begin
                  if (!gotLow) setValue[7:0]  <= ep0Rx.data;  // Low byte first
                  else         setValue[15:8] <= ep0Rx.data;
                  gotLow <= 1'b1;
               end
            end
            STATUS: begin
               if (inAck) begin
                  // New settings only once the host has the status
                  if (isStd && setup.request == `SET_ADDRESS)
                     address <= setup.value[6:0];
                  if (isStd && setup.request == `SET_INTERFACE &&
                      setup.index == {8'd0, `STREAM_INTERFACE})
                     active <= setup.value[0];
                  tx.ready <= 1'b0;
                  state    <= IDLE;
               end
            end
            SEND: begin
               if (ep0Rx.valid && ep0Rx.eop) begin
                  tx.ready <= 1'b0;             // Host moved to status early
                  state    <= IDLE;
               end else if (error) begin
                  {shiftReg, tx.data} <= reply; // Restart from first byte
                  bytesLeft           <= replyLen;
               end else if (!inWaitRequest) begin
                  if (bytesLeft == 2'd1) begin
                     tx.ready <= 1'b0;
                     state    <= WAIT_ACK;
                  end else begin
                     {shiftReg, tx.data} <= {8'd0, shiftReg};
                     bytesLeft           <= bytesLeft - 2'd1;
                  end
               end
            end
            WAIT_ACK: begin
               if (error) begin
                  {shiftReg, tx.data} <= reply;
                  bytesLeft           <= replyLen;
                  tx.ready            <= 1'b1;
                  state               <= SEND;
               end else if (inAck) begin
                  tx.seq        <= ~tx.seq;
                  tx.zeroLength <= 1'b1;
                  tx.ready      <= 1'b1;
                  state         <= GET_STATUS;
               end
            end
            GET_STATUS: begin
               if (ep0Rx.valid && ep0Rx.eop) begin
                  tx.ready <= 1'b0;             // Status OUT closes the transfer
                  state    <= IDLE;
               end else if (inAck) begin
                  tx.seq <= ~tx.seq;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

/* audioFifo.sv */
//--------------------------------------------------------------------------
// Isochronous sample buffer
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "usbAudio_params.svh"

module audioFifo (
   input  logic                Clk,
   input  logic                rst,
   input  logic                active,
   input  logic [3:0]          endpoint,
   input  usbAudioPkg::rxPktT  rx,
   input  logic                audioClk,     // 48 kHz, asynchronous
   output usbAudioPkg::sampleT sample        // Updated after audioClk falls
);

   localparam int AW = `FIFO_ADDR_BITS;

   usbAudioPkg::sampleT mem [2**AW];
   usbAudioPkg::sampleT memQ;
   logic [AW+1:0]       wrAddr;      // Byte address, 4 bytes per word
   logic [AW-1:0]       rdAddr;      // Word address
   logic [AW-1:0]       level;
   logic                fifoReady;
   logic [1:0]          audioSync;
   logic                ep1Byte, ep1Eop, audioFall;

   assign ep1Byte   = active && (endpoint == 4'd1) && rx.valid && !rx.eop;
   assign ep1Eop    = (endpoint == 4'd1) && rx.valid && rx.eop;
   assign audioFall = audioSync == 2'b10;

   //-----------------------------------------------------------------------
   // RAM, byte write and word read
   //-----------------------------------------------------------------------
   always_ff @(posedge Clk) begin
      if (ep1Byte)
         mem[wrAddr[AW+1:2]][8*wrAddr[1:0] +: 8] <= rx.data;   // L lo, L hi, R lo, R hi
      memQ <= mem[rdAddr];
   end

   // Write side
   always_ff @(posedge Clk) begin
      if (rst || !active)
         wrAddr <= '0;
      else if (ep1Byte)
         wrAddr <= wrAddr + 1'b1;
      else if (ep1Eop)
         wrAddr[1:0] <= 2'd0;       // Realign in case a byte got lost
   end

   //-----------------------------------------------------------------------
   // Fill level and audio clock release
   //-----------------------------------------------------------------------
   always_ff @(posedge Clk) begin
      level <= wrAddr[AW+1:2] - rdAddr;   // One cycle behind the pointers
      if (rst) audioSync <= 2'b00;
      else     audioSync <= {audioSync[0], audioClk};
   end

   always_ff @(posedge Clk) begin
      if (rst || !active) begin
         rdAddr    <= '0;
         fifoReady <= 1'b0;
         sample    <= '0;
      end else begin
         // Start/stop hysteresis
         if (fifoReady && level < `FIFO_STOP_LEVEL)
            fifoReady <= 1'b0;
         else if (!fifoReady && level > `FIFO_START_LEVEL)
            fifoReady <= 1'b1;

         if (!fifoReady) begin
            sample <= '0;                   // Silence while filling
         end else if (audioFall) begin
            sample <= memQ;
            rdAddr <= rdAddr + 1'b1;
         end
      end
   end

endmodule

/* usbAudio.sv */
//--------------------------------------------------------------------------
// USB speaker top level
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module usbAudio (
   input  logic                 Clk,
   input  logic                 rst,
   input  logic                 busReset,
   input  logic [3:0]           endpoint,
   input  usbAudioPkg::rxPktT   rx,
   input  logic                 inWaitRequest,
   input  logic                 inAck,
   input  logic                 error,
   input  logic                 audioClk,
   output usbAudioPkg::txPktT   tx,
   output logic                 stall,
   output logic [6:0]           address,
   output logic                 active,
   output logic                 mute,
   output usbAudioPkg::volumeT  volume,
   output usbAudioPkg::sampleT  sample
);

   usbAudioPkg::rxPktT ep0Rx;     // Endpoint 0 only
   usbAudioPkg::setupT setup;
   logic               setupDone;

   setupParser parser (
      .Clk       (Clk),
      .rst       (rst),
      .endpoint  (endpoint),
      .rx        (rx),
      .ep0Rx     (ep0Rx),
      .setup     (setup),
      .setupDone (setupDone)
   );

   controlEndpoint control (
      .Clk           (Clk),
      .rst           (rst),
      .busReset      (busReset),
      .ep0Rx         (ep0Rx),
      .setup         (setup),
      .setupDone     (setupDone),
      .inWaitRequest (inWaitRequest),
      .inAck         (inAck),
      .error         (error),
      .tx            (tx),
      .stall         (stall),
      .address       (address),
      .active        (active),
      .mute          (mute),
      .volume        (volume)
   );

   // Streaming endpoint 1 bypasses the parser
   audioFifo fifo (
      .Clk      (Clk),
      .rst      (rst),
      .active   (active),
      .endpoint (endpoint),
      .rx       (rx),
      .audioClk (audioClk),
      .sample   (sample)
   );

endmodule

/* tbUsbAudio.sv */
//--------------------------------------------------------------------------
// USB speaker testbench
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "usbAudio_params.svh"

module tbUsbAudio;

   logic                Clk = 1'b0;
   logic                rst;
   logic                busReset;
   logic [3:0]          endpoint;
   usbAudioPkg::rxPktT  rx;
   logic                inWaitRequest;
   logic                inAck;
   logic                error;
   logic                audioClk = 1'b0;     // 48 Clk periods per half cycle
   usbAudioPkg::txPktT  tx;
   logic                stall;
   logic [6:0]          address;
   logic                active;
   logic                mute;
   usbAudioPkg::volumeT volume;
   usbAudioPkg::sampleT sample;

   logic [31:0] lcgState = 32'h9d719a3b;
   logic [7:0]  pkt[$];                      // Next OUT packet payload
   logic [31:0] words[$];                    // Written on endpoint 1
   logic [31:0] heard[$];                    // Nonzero samples, one per audio period
   logic        monitorOn = 1'b0;
   logic        finished = 1'b0;             // Silence after playback
   int          audioCount = 0;
   logic [31:0] r;
   logic [15:0] vol;
   int          n;

   usbAudio DUT (.*);

   always #10 Clk = ~Clk;

   //-----------------------------------------------------------------------
   // Failure reporting and helpers
   //-----------------------------------------------------------------------
   task automatic stopRun();
      $display("Some tests failed");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic abortRun(input string why);
      $display("%s", why);
      stopRun();
   endtask

   task automatic checkEqual(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("Fail %s exp %h got %h", name, exp, got);
         stopRun();
      end
   endtask

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic usbAudioPkg::rxPktT rxWord(input logic sop, input logic eop,
                                                 input logic isSetup,
                                                 input logic [7:0] data);
      usbAudioPkg::rxPktT p;
      p.valid = 1'b1;
      p.sop   = sop;
      p.eop   = eop;
      p.setup = isSetup;
      p.data  = data;
      return p;
   endfunction

   //-----------------------------------------------------------------------
   // Transceiver model
   //-----------------------------------------------------------------------

   // One OUT packet from pkt, then the EoP strobe
   task automatic pushPacket(input logic [3:0] ep, input logic isSetup);
      foreach (pkt[i]) begin
         @(posedge Clk);
         endpoint <= ep;
         rx       <= rxWord(i == 0, 1'b0, isSetup, pkt[i]);
      end
      @(posedge Clk);
      endpoint <= ep;
      rx       <= rxWord(pkt.size() == 0, 1'b1, isSetup, 8'h00);  // ZLP is SoP+EoP
      @(posedge Clk);
      rx <= '0;
   endtask

   // Endpoint 1 packets of ten LCG words each, also kept in words
   task automatic streamWords(input int packets);
      logic [31:0] w;
      for (int p = 0; p < packets; p++) begin
         pkt.delete();
         for (int k = 0; k < 10; k++) begin           // 40-byte packets
            w = nextRand();
            if (w == 32'd0) w = 32'd1;                // Zero reads as silence
            words.push_back(w);
            pkt.push_back(w[7:0]);                    // L lo, L hi, R lo, R hi
            pkt.push_back(w[15:8]);
            pkt.push_back(w[23:16]);
            pkt.push_back(w[31:24]);
         end
         pushPacket(4'd1, 1'b0);
      end
   endtask

   task automatic issueSetup(input logic [7:0] requestType, input logic [7:0] request,
                             input logic [15:0] value, input logic [15:0] index,
                             input logic [15:0] length);
      pkt.delete();
      pkt.push_back(requestType);
      pkt.push_back(request);
      pkt.push_back(value[7:0]);           // Little endian fields
      pkt.push_back(value[15:8]);
      pkt.push_back(index[7:0]);
      pkt.push_back(index[15:8]);
      pkt.push_back(length[7:0]);
      pkt.push_back(length[15:8]);
      pushPacket(4'd0, 1'b1);
      repeat (2) @(posedge Clk);           // Bus turnaround
   endtask

   task automatic awaitStatus();
      int cycles;
      cycles = 0;
      @(posedge Clk);
      while (!(tx.ready && tx.zeroLength)) begin
         cycles++;
         if (cycles > 50) abortRun("Timeout waiting for the zero-length status");
         @(posedge Clk);
      end
   endtask

   // Host acks the status packet
   task automatic ackStatus();
      inAck <= 1'b1;
      @(posedge Clk);
      inAck <= 1'b0;
      @(posedge Clk);
      checkEqual("tx.ready", 32'(tx.ready), 32'd0);
   endtask

   // Control read data stage under random back-pressure, then status
   task automatic readReply(input int len, input logic [15:0] exp);
      int          taken;
      int          cycles;
      logic [15:0] got;
      logic [31:0] rnd;
      taken  = 0;
      cycles = 0;
      got    = '0;
      while (taken < len) begin
         @(posedge Clk);
         cycles++;
         if (cycles > 200) abortRun("Timeout waiting for IN data bytes");
         if (tx.ready && !inWaitRequest) begin     // DUT takes this byte too
            checkEqual("tx.zeroLength", 32'(tx.zeroLength), 32'd0);
            checkEqual("tx.seq", 32'(tx.seq), 32'd1);
            got[8*taken +: 8] = tx.data;
            taken++;
         end
         rnd = nextRand();
         if (taken < len) inWaitRequest <= rnd[28];
         else             inWaitRequest <= 1'b1;   // Idle between IN tokens
      end
      inAck <= 1'b1;
      @(posedge Clk);
      checkEqual("tx.ready", 32'(tx.ready), 32'd0); // Dropped after the last byte
      inAck <= 1'b0;
      @(posedge Clk);
      checkEqual("tx.ready", 32'(tx.ready), 32'd1);
      checkEqual("tx.zeroLength", 32'(tx.zeroLength), 32'd1);
      checkEqual("tx.seq", 32'(tx.seq), 32'd0);    // Toggled on ack
      pkt.delete();
      pushPacket(4'd0, 1'b0);                      // Status OUT
      @(posedge Clk);
      checkEqual("tx.ready", 32'(tx.ready), 32'd0);
      checkEqual("tx.data", 32'(got), 32'(exp));
   endtask

   //-----------------------------------------------------------------------
   // Audio clock and sample monitor
   //-----------------------------------------------------------------------
   always @(posedge Clk) begin
      if (audioCount == 47) begin
         audioCount <= 0;
         audioClk   <= ~audioClk;
         if (monitorOn && !audioClk) begin         // Mid period, sample is settled
            if (sample != '0) begin
               assert (!finished) else abortRun("Sample resumed after playback stopped");
               heard.push_back(sample);
            end else if (heard.size() > 0) begin
               finished = 1'b1;
            end
         end
      end else begin
         audioCount <= audioCount + 1;
      end
   end

   //-----------------------------------------------------------------------
   // Stimulus
   //-----------------------------------------------------------------------
   initial begin
      rst           <= 1'b1;
      busReset      <= 1'b0;
      endpoint      <= 4'd0;
      rx            <= '0;
      inWaitRequest <= 1'b1;
      inAck         <= 1'b0;
      error         <= 1'b0;
      repeat (4) @(posedge Clk);
      rst <= 1'b0;
      repeat (2) @(posedge Clk);

      // Reset values
      checkEqual("active", 32'(active), 32'd0);
      checkEqual("mute", 32'(mute), 32'd0);
      checkEqual("stall", 32'(stall), 32'd0);
      checkEqual("tx.ready", 32'(tx.ready), 32'd0);
      checkEqual("address", 32'(address), 32'd0);
      checkEqual("volume.left", 32'(volume.left), 32'(`VOLUME_DEFAULT));
      checkEqual("volume.right", 32'(volume.right), 32'(`VOLUME_DEFAULT));

      // Address applies only after the status ack
      issueSetup(8'h00, `SET_ADDRESS, 16'h002A, 16'h0000, 16'h0000);
      awaitStatus();
      checkEqual("address", 32'(address), 32'd0);
      ackStatus();
      checkEqual("address", 32'(address), 32'h2A);

      issueSetup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'h0040);   // GET_DESCRIPTOR
      n = 0;
      while (!stall) begin
         @(posedge Clk);
         n++;
         if (n > 20) abortRun("No stall on an unsupported request");
      end

      // SET_CUR volume left and mute
      r   = nextRand();
      vol = r[15:0];
      issueSetup(8'h21, `SET_CUR, {`VOLUME_CONTROL, 8'd1}, {`FEATURE_UNIT, 8'd0}, 16'd2);
      pkt.delete();
      pkt.push_back(vol[7:0]);
      pkt.push_back(vol[15:8]);
      pushPacket(4'd0, 1'b0);
      awaitStatus();
      ackStatus();
      checkEqual("stall", 32'(stall), 32'd0);
      checkEqual("volume.left", 32'(volume.left), 32'(vol));
      checkEqual("volume.right", 32'(volume.right), 32'(`VOLUME_DEFAULT));
      issueSetup(8'h21, `SET_CUR, {`MUTE_CONTROL, 8'd0}, {`FEATURE_UNIT, 8'd0}, 16'd1);
      pkt.delete();
      pkt.push_back(8'h01);
      pushPacket(4'd0, 1'b0);
      awaitStatus();
      ackStatus();
      checkEqual("mute", 32'(mute), 32'd1);

      // Read back, then fixed range on channel 2
      issueSetup(8'hA1, `GET_CUR, {`VOLUME_CONTROL, 8'd1}, {`FEATURE_UNIT, 8'd0}, 16'd2);
      readReply(2, vol);
      issueSetup(8'hA1, `GET_CUR, {`MUTE_CONTROL, 8'd0}, {`FEATURE_UNIT, 8'd0}, 16'd1);
      readReply(1, 16'h0001);
      issueSetup(8'hA1, `GET_MIN, {`VOLUME_CONTROL, 8'd2}, {`FEATURE_UNIT, 8'd0}, 16'd2);
      readReply(2, `VOLUME_MIN);
      issueSetup(8'hA1, `GET_MAX, {`VOLUME_CONTROL, 8'd2}, {`FEATURE_UNIT, 8'd0}, 16'd2);
      readReply(2, `VOLUME_MAX);
      issueSetup(8'hA1, `GET_RES, {`VOLUME_CONTROL, 8'd2}, {`FEATURE_UNIT, 8'd0}, 16'd2);
      readReply(2, `VOLUME_RES);

      //--------------------------------------------------------------------
      // Playback
      //--------------------------------------------------------------------
      issueSetup(8'h01, `SET_INTERFACE, 16'h0001, {8'd0, `STREAM_INTERFACE}, 16'd0);
      awaitStatus();
      checkEqual("active", 32'(active), 32'd0);
      ackStatus();
      checkEqual("active", 32'(active), 32'd1);
      monitorOn = 1'b1;
      streamWords(16);
      n = 0;
      while (!finished) begin
         @(posedge Clk);
         n++;
         if (n > 40000) abortRun("Timeout waiting for playback to stop");
      end
      assert (heard.size() >= 128 && heard.size() <= words.size())
      else abortRun("Wrong number of samples played before silence");
      foreach (heard[i]) checkEqual("sample", heard[i], words[i]);

      // Refill so that the deactivation cuts a running playback
      monitorOn = 1'b0;
      streamWords(10);
      n = 0;
      while (sample == '0) begin
         @(posedge Clk);
         n++;
         if (n > 2000) abortRun("Timeout waiting for playback to resume");
      end

      // Deactivate, output stays silent
      issueSetup(8'h01, `SET_INTERFACE, 16'h0000, {8'd0, `STREAM_INTERFACE}, 16'd0);
      awaitStatus();
      ackStatus();
      checkEqual("active", 32'(active), 32'd0);
      repeat (300) begin
         @(posedge Clk);
         checkEqual("sample", sample, 32'd0);
      end

      $display("All tests passed");
      $finish;
   end

endmodule

/* usbAudio.f */
+incdir+.
usbAudioPkg.sv
setupParser.sv
controlEndpoint.sv
audioFifo.sv
usbAudio.sv
tbUsbAudio.sv

/* Makefile */
# Verilator build and run for the USB speaker testbench

VERILATOR ?= verilator
TOP       ?= tbUsbAudio
FILELIST  ?= usbAudio.f
FLAGS     ?= -j 0

OBJDIR  := obj_dir
BINARY  := $(OBJDIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) usbAudio_params.svh

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(FLAGS) --top-module $(TOP) \
		--Mdir $(OBJDIR) -f $(FILELIST)

# $fatal in the testbench gives a nonzero exit status
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(OBJDIR)
